/* list.f */
verilog/cnn_cfg_pkg.sv
verilog/cnn_bus_pkg.sv
verilog/layer_sequencer.sv
verilog/sample_feeder.sv
verilog/mac_lane.sv
verilog/result_collector.sv
verilog/cnn_engine.sv
sim/tb_clock.sv
sim/tb_cnn_engine.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_cnn_engine -f list.f -o sim_cnn_engine &&
./obj_dir/sim_cnn_engine 2>&1 | awk '{ print } /^\*\* PASS \*\*$/ { hit = 1 } END { exit !hit }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* sim/tb_clock.sv */
`default_nettype none

// free-running clock plus synchronous reset
module tb_clock (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int half_period  = 50; // 100 ns period
	localparam int reset_cycles = 4;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// released on the 4th rising edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* sim/tb_cnn_engine.sv */
`default_nettype none

module tb_cnn_engine;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int row_count   = 4;
	localparam int wait_limit  = 100; // cycles per wait
	localparam int quiet_count = 20;  // idle cycles watched after done

	logic                       clk;
	logic                       reset;
	logic                       start;
	cnn_bus_pkg::fm_write_t     fm_wr;
	cnn_bus_pkg::wt_write_t     wt_wr;
	wire cnn_bus_pkg::result_t  res;
	wire                        busy;
	wire                        done;

	// stimulus table, one row per run
	string       row_name [row_count];
	logic [31:0] row_seed [row_count];
	logic [1:0]  row_mode [row_count]; // 0 random, 1 all -128, 2 -128 x +127

	logic signed [7:0] fm_img [cnn_cfg_pkg::fm_depth];                 // host copy of buffer
	logic signed [7:0] wt_img [cnn_cfg_pkg::lanes][cnn_cfg_pkg::wt_depth]; // host copy of weights
	logic [31:0]       lcg_state;
	int                done_count;

	tb_clock i_tb_clock (.clk(clk), .reset(reset));

	cnn_engine i_cnn_engine (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.fm_wr (fm_wr),
		.wt_wr (wt_wr),
		.res   (res),
		.busy  (busy),
		.done  (done)
	);

	// counts every done pulse, independent of the checks
	always @(posedge clk) begin
		if (!reset && done)
			done_count <= done_count + 1;
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// reference from the layer rules, bank k for layer k
	function automatic int model_value(input int layer, input int lane);
		int taps;
		int prod;
		int acc;
		taps = (layer == 1) ? 16 : 9;
		acc = 0;
		for (int t = 0; t < taps; t++) begin
			prod = int'(fm_img[t]) * int'(wt_img[lane][layer * 16 + t]);
			if (t == 0)
				acc = prod; // first product seeds sum and max
			else if (layer == 2)
				acc = (prod > acc) ? prod : acc;
			else
				acc = acc + prod;
		end
		if (layer == 0 && acc < 0)
			acc = 0; // relu
		return acc;
	endfunction

	task automatic check_value(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("** FAIL **");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic fill_images(input logic [1:0] mode, input logic [31:0] seed);
		lcg_state = 32'h941c7232 ^ seed;
		for (int a = 0; a < cnn_cfg_pkg::fm_depth; a++) begin
			lcg_state = lcg_next(lcg_state);
			fm_img[a] = (mode == 2'd0) ? lcg_state[23:16] : 8'h80;
		end
		for (int l = 0; l < cnn_cfg_pkg::lanes; l++) begin
			for (int a = 0; a < cnn_cfg_pkg::wt_depth; a++) begin
				lcg_state = lcg_next(lcg_state);
				case (mode)
					2'd0:    wt_img[l][a] = lcg_state[23:16];
					2'd1:    wt_img[l][a] = 8'h80; // -128
					default: wt_img[l][a] = 8'h7f; // +127
				endcase
			end
		end
	endtask

	// one write per rising edge
	task automatic load_images();
		for (int a = 0; a < cnn_cfg_pkg::fm_depth; a++) begin
			@(posedge clk);
			fm_wr <= '{we: 1'b1, addr: 4'(a), data: fm_img[a]};
		end
		@(posedge clk);
		fm_wr <= '0;
		for (int l = 0; l < cnn_cfg_pkg::lanes; l++) begin
			for (int a = 0; a < cnn_cfg_pkg::wt_depth; a++) begin
				@(posedge clk);
				wt_wr <= '{we: 1'b1, lane: 2'(l), addr: 6'(a), data: wt_img[l][a]};
			end
		end
		@(posedge clk);
		wt_wr <= '0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// busy must hold and done stay low while results are due
	task automatic wait_result(input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			check_value({what, " busy"}, 1, busy);
			check_value({what, " early done"}, 0, done);
		end while (!res.valid && n < wait_limit);
		if (!res.valid)
			fail_timeout(what);
	endtask

	task automatic wait_done(input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			check_value({what, " extra result"}, 0, res.valid);
			check_value({what, " busy before done"}, 1, busy);
		end while (!done && n < wait_limit);
		if (!done)
			fail_timeout({what, " done"});
	endtask

	////////////////////
	// one table row
	////////////////////

	task automatic run_row(input int r);
		string tag;
		int    expected_done;
		expected_done = done_count + 1;
		fill_images(row_mode[r], row_seed[r]);
		load_images();
		pulse_start();
		@(negedge clk);
		check_value({row_name[r], " busy after start"}, 1, busy);
		pulse_start(); // lands while busy, must be dropped
		for (int k = 0; k < 12; k++) begin
			tag = $sformatf("%s result %0d", row_name[r], k);
			wait_result(tag);
			check_value({tag, " layer"}, k / 4, res.layer); // layer major
			check_value({tag, " lane"}, k % 4, res.lane);
			check_value({tag, " value"}, model_value(k / 4, k % 4), res.value);
		end
		wait_done(row_name[r]);
		for (int c = 0; c < quiet_count; c++) begin
			@(negedge clk);
			check_value({row_name[r], " idle result"}, 0, res.valid);
			check_value({row_name[r], " idle done"}, 0, done);
			check_value({row_name[r], " idle busy"}, 0, busy);
		end
		check_value({row_name[r], " done pulses"}, expected_done, done_count);
	endtask

	////////////////////
	// main
	////////////////////

	initial begin
		start      = 1'b0;
		fm_wr      = '0;
		wt_wr      = '0;
		done_count = 0;

		row_name[0] = "random_a";
		row_seed[0] = 32'h00000000;
		row_mode[0] = 2'd0;
		row_name[1] = "random_b";
		row_seed[1] = 32'h5a5a0001;
		row_mode[1] = 2'd0;
		row_name[2] = "neg_times_neg"; // full 20-bit range on layer 1
		row_seed[2] = 32'h00000002;
		row_mode[2] = 2'd1;
		row_name[3] = "neg_times_pos"; // relu clamp, all products negative
		row_seed[3] = 32'h00000003;
		row_mode[3] = 2'd2;

		begin : reset_release
			int n;
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (reset && n < wait_limit);
			if (reset)
				fail_timeout("reset release");
		end

		// quiet before any start
		for (int c = 0; c < 5; c++) begin
			@(negedge clk);
			check_value("after reset busy", 0, busy);
			check_value("after reset done", 0, done);
			check_value("after reset result", 0, res.valid);
		end

		for (int r = 0; r < row_count; r++)
			run_row(r);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cnn_bus_pkg.sv */
`default_nettype none

package cnn_bus_pkg;

	// sequencer FSM
	typedef enum logic [1:0] {
		seq_idle = 2'd0,
		seq_go   = 2'd1, // one cycle, issues layer_go
		seq_wait = 2'd2, // layer running
		seq_done = 2'd3  // done pulse
	} seq_state_t;

	////////////////////
	// write ports
	////////////////////

	typedef struct packed {
		logic                                 we;
		logic [cnn_cfg_pkg::fm_addr_w-1:0]    addr;
		logic signed [cnn_cfg_pkg::data_w-1:0] data;
	} fm_write_t;

	typedef struct packed {
		logic                                  we;
		logic [cnn_cfg_pkg::lane_w-1:0]        lane; // target lane
		logic [cnn_cfg_pkg::wt_addr_w-1:0]     addr;
		logic signed [cnn_cfg_pkg::data_w-1:0] data;
	} wt_write_t;

	////////////////////
	// datapath streams
	////////////////////

	typedef struct packed {
		logic                                  valid;
		logic                                  first; // tap 0
		logic                                  last;  // final tap of the layer
		logic [cnn_cfg_pkg::fm_addr_w-1:0]     tap;
		logic signed [cnn_cfg_pkg::data_w-1:0] data;
	} sample_t;

	typedef struct packed {
		logic                                 valid;
		logic signed [cnn_cfg_pkg::acc_w-1:0] value;
	} lane_result_t;

	typedef struct packed {
		logic                                 valid;
		logic [cnn_cfg_pkg::layer_w-1:0]      layer;
		logic [cnn_cfg_pkg::lane_w-1:0]       lane;
		logic signed [cnn_cfg_pkg::acc_w-1:0] value;
	} result_t;

endpackage

`default_nettype wire

/* verilog/cnn_cfg_pkg.sv */
`default_nettype none

package cnn_cfg_pkg;

	////////////////////
	// engine sizes
	////////////////////

	localparam int lanes      = 4;  // parallel MAC lanes
	localparam int lane_w     = 2;  // lane select width
	localparam int data_w     = 8;  // signed samples and weights
	localparam int acc_w      = 20; // accumulator and result width

	localparam int fm_depth   = 16; // feature buffer entries
	localparam int fm_addr_w  = 4;

	localparam int bank_depth = 16; // weights per layer bank
	localparam int wt_depth   = 48; // three banks per lane
	localparam int wt_addr_w  = 6;

	localparam int layer_count = 3;
	localparam int layer_w     = 2; // also the bank select width

	////////////////////
	// layer descriptors
	////////////////////

	typedef enum logic [1:0] {
		op_mac_relu = 2'd0, // sum of products, negatives clamped
		op_mac      = 2'd1, // plain sum, fc stand-in
		op_max      = 2'd2  // max of products, pool stand-in
	} layer_op_t;

	typedef struct packed {
		layer_op_t              op;
		logic [fm_addr_w-1:0]   taps_m1; // tap count minus one
		logic [layer_w-1:0]     bank;    // weight bank in each lane
	} layer_cfg_t;

	// fixed network structure, indexed by layer_num
	localparam layer_cfg_t layer_table [layer_count] = '{
		'{op: op_mac_relu, taps_m1: 4'd8,  bank: 2'd0}, // 9-tap conv + relu
		'{op: op_mac,      taps_m1: 4'd15, bank: 2'd1}, // 16-tap fc
		'{op: op_max,      taps_m1: 4'd8,  bank: 2'd2}  // 9-tap max
	};

endpackage

`default_nettype wire

/* verilog/cnn_engine.sv */
`default_nettype none

// top, sequencer + feeder + lanes + collector
module cnn_engine (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         start, // ignored while busy
	input  wire cnn_bus_pkg::fm_write_t fm_wr,
	input  wire cnn_bus_pkg::wt_write_t wt_wr, // broadcast, lane field selects
	output wire cnn_bus_pkg::result_t   res,
	output wire                         busy,
	output wire                         done
);

	wire                                layer_go;
	wire cnn_cfg_pkg::layer_cfg_t       layer_cfg;
	wire [cnn_cfg_pkg::layer_w-1:0]     layer_num;
	wire                                layer_ready;
	wire cnn_bus_pkg::sample_t          sample;    // broadcast to all lanes
	wire cnn_bus_pkg::lane_result_t     lane_res [cnn_cfg_pkg::lanes];

	////////////////////
	// control
	////////////////////

	layer_sequencer i_layer_sequencer (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.layer_ready (layer_ready),
		.layer_go    (layer_go),
		.layer_cfg   (layer_cfg),
		.layer_num   (layer_num),
		.busy        (busy),
		.done        (done)
	);

	////////////////////
	// datapath
	////////////////////

	sample_feeder i_sample_feeder (
		.clk       (clk),
		.reset     (reset),
		.fm_wr     (fm_wr),
		.layer_go  (layer_go),
		.layer_cfg (layer_cfg),
		.sample    (sample)
	);

	for (genvar g = 0; g < cnn_cfg_pkg::lanes; g++) begin : g_lane
		mac_lane #(
			.lane_index (g)
		) i_mac_lane (
			.clk       (clk),
			.reset     (reset),
			.wt_wr     (wt_wr),
			.layer_cfg (layer_cfg),
			.sample    (sample),
			.lane_res  (lane_res[g])
		);
	end

	result_collector i_result_collector (
		.clk         (clk),
		.reset       (reset),
		.lane_res    (lane_res),
		.layer_num   (layer_num),
		.res         (res),
		.layer_ready (layer_ready) // back to the sequencer
	);

endmodule

`default_nettype wire

/* verilog/layer_sequencer.sv */
`default_nettype none

// walks the fixed layer table, one go pulse per layer
module layer_sequencer (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              start,       // single-cycle pulse
	input  wire                              layer_ready, // collector drained the layer
	output logic                             layer_go,
	output cnn_cfg_pkg::layer_cfg_t          layer_cfg,
	output logic [cnn_cfg_pkg::layer_w-1:0]  layer_num,
	output logic                             busy,
	output logic                             done
);

	cnn_bus_pkg::seq_state_t state;
	logic                    last_layer;

	// final entry of the table reached
	assign last_layer = (layer_num == cnn_cfg_pkg::layer_w'(cnn_cfg_pkg::layer_count - 1));

	////////////////////
	// state and layer count
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= cnn_bus_pkg::seq_idle;
			layer_num <= '0;
		end else begin
			case (state)
				cnn_bus_pkg::seq_idle: begin
					if (start) begin // start only counts here
						layer_num <= '0;
						state     <= cnn_bus_pkg::seq_go;
					end
				end
				cnn_bus_pkg::seq_go: begin
					state <= cnn_bus_pkg::seq_wait; // go lasts one cycle
				end
				cnn_bus_pkg::seq_wait: begin
					if (layer_ready) begin
						if (last_layer) begin
							state <= cnn_bus_pkg::seq_done;
						end else begin
							layer_num <= layer_num + 1'b1; // next table entry
							state     <= cnn_bus_pkg::seq_go;
						end
					end
				end
				cnn_bus_pkg::seq_done: begin
					state <= cnn_bus_pkg::seq_idle;
				end
				default: begin
					state <= cnn_bus_pkg::seq_idle;
				end
			endcase
		end
	end

	////////////////////
	// outputs
	////////////////////

	// descriptor follows layer_num, so it stays put from one go to the next
	assign layer_cfg = cnn_cfg_pkg::layer_table[layer_num];

	assign layer_go = (state == cnn_bus_pkg::seq_go);
	assign busy     = (state != cnn_bus_pkg::seq_idle); // high through seq_done
	assign done     = (state == cnn_bus_pkg::seq_done);

endmodule

`default_nettype wire

/* verilog/mac_lane.sv */
`default_nettype none

// one compute lane with its own weight store
module mac_lane #(
	parameter int lane_index = 0
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire cnn_bus_pkg::wt_write_t  wt_wr,
	input  wire cnn_cfg_pkg::layer_cfg_t layer_cfg,
	input  wire cnn_bus_pkg::sample_t    sample,
	output cnn_bus_pkg::lane_result_t    lane_res
);

	logic signed [cnn_cfg_pkg::data_w-1:0]   wt_mem [cnn_cfg_pkg::wt_depth];
	logic [cnn_cfg_pkg::wt_addr_w-1:0]       rd_addr;
	logic signed [cnn_cfg_pkg::data_w-1:0]   w_q;     // weight for this tap
	logic signed [cnn_cfg_pkg::data_w-1:0]   d_q;     // sample, delayed to match
	logic                                    valid_q;
	logic                                    first_q;
	logic                                    last_q;
	logic signed [2*cnn_cfg_pkg::data_w-1:0] prod;
	logic signed [cnn_cfg_pkg::acc_w-1:0]    prod_ext;
	logic signed [cnn_cfg_pkg::acc_w-1:0]    acc;
	logic signed [cnn_cfg_pkg::acc_w-1:0]    acc_next;
	logic                                    out_valid;
	logic signed [cnn_cfg_pkg::acc_w-1:0]    out_value;

	// only writes aimed at this lane
	always_ff @(posedge clk) begin
		if (wt_wr.we && (wt_wr.lane == cnn_cfg_pkg::lane_w'(lane_index)))
			wt_mem[wt_wr.addr] <= wt_wr.data;
	end

	// bank base plus tap
	assign rd_addr = cnn_cfg_pkg::wt_addr_w'(layer_cfg.bank)
		* cnn_cfg_pkg::wt_addr_w'(cnn_cfg_pkg::bank_depth)
		+ cnn_cfg_pkg::wt_addr_w'(sample.tap);

	////////////////////
	// stage 1, weight read
	////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= sample.valid;
	end

	always_ff @(posedge clk) begin
		w_q     <= wt_mem[rd_addr];
		d_q     <= sample.data;
		first_q <= sample.first;
		last_q  <= sample.last;
	end

	////////////////////
	// stage 2, accumulate
	////////////////////

	assign prod     = d_q * w_q;
	assign prod_ext = prod; // sign extends

	always_comb begin
		if (first_q)
			acc_next = prod_ext; // seeds sum and max alike
		else if (layer_cfg.op == cnn_cfg_pkg::op_max)
			acc_next = (prod_ext > acc) ? prod_ext : acc;
		else
			acc_next = acc + prod_ext;
	end

	always_ff @(posedge clk) begin
		if (valid_q)
			acc <= acc_next;
		if (valid_q && last_q) begin
			if ((layer_cfg.op == cnn_cfg_pkg::op_mac_relu) && acc_next[cnn_cfg_pkg::acc_w-1])
				out_value <= '0; // relu
			else
				out_value <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= valid_q && last_q;
	end

	assign lane_res = '{valid: out_valid, value: out_value};

endmodule

`default_nettype wire

/* verilog/result_collector.sv */
`default_nettype none

// serializes the lane results, one per cycle
module result_collector (
	input  wire                             clk,
	input  wire                             reset,
	input  wire cnn_bus_pkg::lane_result_t  lane_res [cnn_cfg_pkg::lanes],
	input  wire [cnn_cfg_pkg::layer_w-1:0]  layer_num,
	output cnn_bus_pkg::result_t            res,
	output logic                            layer_ready
);

	logic signed [cnn_cfg_pkg::acc_w-1:0] hold [cnn_cfg_pkg::lanes]; // latched lane values
	logic                                 sending;
	logic [cnn_cfg_pkg::lane_w-1:0]       idx;     // lane being emitted
	logic                                 res_valid;
	logic [cnn_cfg_pkg::layer_w-1:0]      res_layer;
	logic [cnn_cfg_pkg::lane_w-1:0]       res_lane;
	logic signed [cnn_cfg_pkg::acc_w-1:0] res_value;

	////////////////////
	// drain control
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sending     <= 1'b0;
			idx         <= '0;
			res_valid   <= 1'b0;
			layer_ready <= 1'b0;
		end else begin
			res_valid <= sending;
			// one cycle behind the lane 3 strobe
			layer_ready <= res_valid
				&& (res_lane == cnn_cfg_pkg::lane_w'(cnn_cfg_pkg::lanes - 1));
			if (lane_res[0].valid) begin // all lanes strobe together
				sending <= 1'b1;
				idx     <= '0;
			end else if (sending) begin
				if (idx == cnn_cfg_pkg::lane_w'(cnn_cfg_pkg::lanes - 1))
					sending <= 1'b0;
				idx <= idx + 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (lane_res[0].valid) begin
			for (int i = 0; i < cnn_cfg_pkg::lanes; i++)
				hold[i] <= lane_res[i].value;
		end
		res_layer <= layer_num; // still current layer here
		res_lane  <= idx;
		res_value <= hold[idx];
	end

	assign res = '{valid: res_valid, layer: res_layer, lane: res_lane, value: res_value};

endmodule

`default_nettype wire

/* verilog/sample_feeder.sv */
`default_nettype none

// feature buffer plus tap streamer
module sample_feeder (
	input  wire                        clk,
	input  wire                        reset,
	input  wire cnn_bus_pkg::fm_write_t fm_wr,
	input  wire                        layer_go,
	input  wire cnn_cfg_pkg::layer_cfg_t layer_cfg,
	output cnn_bus_pkg::sample_t       sample
);

	logic signed [cnn_cfg_pkg::data_w-1:0] fm_mem [cnn_cfg_pkg::fm_depth];

	logic                                  running;  // taps still to issue
	logic [cnn_cfg_pkg::fm_addr_w-1:0]     tap;      // also the read address
	logic                                  smp_valid;
	logic                                  smp_first;
	logic                                  smp_last;
	logic [cnn_cfg_pkg::fm_addr_w-1:0]     smp_tap;
	logic signed [cnn_cfg_pkg::data_w-1:0] smp_data;

	// host write port, open at any time
	always_ff @(posedge clk) begin
		if (fm_wr.we)
			fm_mem[fm_wr.addr] <= fm_wr.data;
	end

	////////////////////
	// tap counter
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			running   <= 1'b0;
			tap       <= '0;
			smp_valid <= 1'b0;
		end else begin
			smp_valid <= running;
			if (layer_go) begin
				running <= 1'b1;
				tap     <= '0; // every layer starts at entry 0
			end else if (running) begin
				if (tap == layer_cfg.taps_m1)
					running <= 1'b0;
				else
					tap <= tap + 1'b1;
			end
		end
	end

	// registered read, lands with the flags
	always_ff @(posedge clk) begin
		smp_data  <= fm_mem[tap];
		smp_tap   <= tap;
		smp_first <= (tap == '0);
		smp_last  <= (tap == layer_cfg.taps_m1);
	end

	assign sample = '{valid: smp_valid, first: smp_first, last: smp_last,
		tap: smp_tap, data: smp_data};

endmodule

`default_nettype wire
